// ==== design/ram_pkg.sv ====
package ram_pkg;

    // Word layout, fixed at four byte lanes
    localparam int data_w = 32;
    localparam int lane_w = 8;
    localparam int lanes = 4;

    typedef logic [data_w-1:0] ram_data_t;
    typedef logic [lanes-1:0] ram_mask_t;
    typedef logic [2:0] rb_reg_t;

    // Register-bus register map
    localparam rb_reg_t rb_addr_reg = 3'd0;
    localparam rb_reg_t rb_wdata_reg = 3'd1;
    localparam rb_reg_t rb_mask_reg = 3'd2;
    localparam rb_reg_t rb_cmd_reg = 3'd3;
    localparam rb_reg_t rb_rdata_reg = 3'd4;
    // Bit 0 is test ownership of both array ports
    localparam rb_reg_t rb_ctrl_reg = 3'd5;

    // Register-bus request, valid whenever sel is high
    // The register index field is named reg_idx since reg is a keyword
    typedef struct packed {
        logic sel;
        logic wr;
        rb_reg_t reg_idx;
        ram_data_t wdata;
    } rb_req_t;

    // Command codes, taken from the low bits of a rb_cmd_reg write
    typedef enum logic [1:0] {
        cmd_write = 2'd1,
        cmd_read = 2'd2
    } rb_cmd_e;

    // Write toward the array, address travels beside it
    typedef struct packed {
        logic en;
        ram_mask_t mask;
        ram_data_t data;
    } mem_wr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_capture
    } rb_state_e;

endpackage

// ==== design/rb_access.sv ====
`timescale 1ns/100ps

module rb_access import ram_pkg::*; #(
    parameter int addr_w = 10
) (
    input  logic              clkdp,
    input  logic              rst,
    input  rb_req_t           rb_req,
    output ram_data_t         rb_rdata,
    output logic              rb_rvalid,
    output logic              rb_busy,
    output logic              test_own,
    output mem_wr_t           test_wr,
    output logic [addr_w-1:0] test_addr,
    output logic              test_rd,
    output logic              capture,
    input  ram_data_t         capture_data
);

    logic [addr_w-1:0] addr_q;
    ram_data_t wdata_q;
    ram_mask_t mask_q;
    ram_data_t rdata_q;
    logic own_q;
    logic cmd_rd_q;
    rb_state_e state;
    rb_state_e state_nxt;
    logic reg_wr;
    logic cmd_go;
    logic rd_pend;
    rb_reg_t rd_reg_q;
    ram_data_t reg_view;

    assign reg_wr = rb_req.sel && rb_req.wr;

    // Only known command codes start an access, and never while busy
    assign cmd_go = reg_wr && (rb_req.reg_idx == rb_cmd_reg) && !rb_busy &&
                    ((rb_req.wdata[1:0] == cmd_write) || (rb_req.wdata[1:0] == cmd_read));

    always_ff @(posedge clkdp) begin
        if (rst) begin
            addr_q <= '0;
            wdata_q <= '0;
            mask_q <= '0;
            own_q <= 1'b0;
            cmd_rd_q <= 1'b0;
        end else if (reg_wr) begin
            case (rb_req.reg_idx)
                rb_addr_reg:  addr_q <= rb_req.wdata[addr_w-1:0];
                rb_wdata_reg: wdata_q <= rb_req.wdata;
                rb_mask_reg:  mask_q <= rb_req.wdata[lanes-1:0];
                rb_ctrl_reg:  own_q <= rb_req.wdata[0];
                rb_cmd_reg: begin
                    if (cmd_go) begin
                        cmd_rd_q <= (rb_req.wdata[1:0] == cmd_read);
                    end
                end
                default: ;
            endcase
        end
    end

    // One array access per command, plus a capture cycle for reads
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (cmd_go) begin
                    state_nxt = st_access;
                end
            end
            st_access:  state_nxt = cmd_rd_q ? st_capture : st_idle;
            st_capture: state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clkdp) begin
        if (rst) begin
            state <= st_idle;
            rdata_q <= '0;
        end else begin
            state <= state_nxt;
            if (capture) begin
                rdata_q <= capture_data;
            end
        end
    end

    assign rb_busy = (state != st_idle);
    assign capture = (state == st_capture);
    assign test_own = own_q;
    assign test_addr = addr_q;
    assign test_rd = (state == st_access) && cmd_rd_q;
    assign test_wr.en = (state == st_access) && !cmd_rd_q;
    assign test_wr.mask = mask_q;
    assign test_wr.data = wdata_q;

    // Register read view, cmd register shows the busy flag
    always_comb begin
        case (rd_reg_q)
            rb_addr_reg:  reg_view = ram_data_t'(addr_q);
            rb_wdata_reg: reg_view = wdata_q;
            rb_mask_reg:  reg_view = ram_data_t'(mask_q);
            rb_cmd_reg:   reg_view = ram_data_t'(rb_busy);
            rb_rdata_reg: reg_view = rdata_q;
            rb_ctrl_reg:  reg_view = ram_data_t'(own_q);
            default:      reg_view = '0;
        endcase
    end

    // Two-stage read return so rvalid lands one cycle after the request edge
    always_ff @(posedge clkdp) begin
        if (rst) begin
            rd_pend <= 1'b0;
            rd_reg_q <= '0;
            rb_rvalid <= 1'b0;
            rb_rdata <= '0;
        end else begin
            rd_pend <= rb_req.sel && !rb_req.wr;
            if (rb_req.sel && !rb_req.wr) begin
                rd_reg_q <= rb_req.reg_idx;
            end
            rb_rvalid <= rd_pend;
            if (rd_pend) begin
                rb_rdata <= reg_view;
            end
        end
    end

endmodule

// ==== design/ram_port_mux.sv ====
`timescale 1ns/100ps

module ram_port_mux import ram_pkg::*; #(
    parameter int addr_w = 10
) (
    input  logic              clkdp,
    input  logic              rst,
    input  logic              test_own,
    input  mem_wr_t           func_wr,
    input  logic [addr_w-1:0] func_wr_addr,
    input  logic              func_rd,
    input  logic [addr_w-1:0] func_rd_addr,
    input  mem_wr_t           test_wr,
    input  logic [addr_w-1:0] test_addr,
    input  logic              test_rd,
    output mem_wr_t           arr_wr,
    output logic [addr_w-1:0] arr_wr_addr,
    output logic              arr_rd,
    output logic [addr_w-1:0] arr_rd_addr,
    output logic              rd_owner
);

    logic use_test;
    mem_wr_t sel_wr;

    // A test access in flight also takes the ports, even without ownership
    assign use_test = test_own || test_wr.en || test_rd;

    always_comb begin
        if (use_test) begin
            sel_wr = test_wr;
            arr_wr_addr = test_addr;
            arr_rd = test_rd;
            arr_rd_addr = test_addr;
        end else begin
            sel_wr = func_wr;
            arr_wr_addr = func_wr_addr;
            arr_rd = func_rd;
            arr_rd_addr = func_rd_addr;
        end
    end

    // Lane enables, zero unless the write strobe is up
    always_comb begin
        arr_wr.mask = sel_wr.en ? sel_wr.mask : '0;
        arr_wr.en = |arr_wr.mask;
        arr_wr.data = sel_wr.data;
    end

    // Remember which side issued the last read for the return path
    always_ff @(posedge clkdp) begin
        if (rst) begin
            rd_owner <= 1'b0;
        end else if (arr_rd) begin
            rd_owner <= use_test;
        end
    end

endmodule

// ==== design/ram_array.sv ====
`timescale 1ns/100ps

module ram_array import ram_pkg::*; #(
    parameter int addr_w = 10
) (
    input  logic              clkdp,
    input  mem_wr_t           arr_wr,
    input  logic [addr_w-1:0] arr_wr_addr,
    input  logic              arr_rd,
    input  logic [addr_w-1:0] arr_rd_addr,
    output ram_data_t         q
);

    // Behavioral stand-in for the dual-port macro
    ram_data_t mem [2**addr_w];

    always_ff @(posedge clkdp) begin
        for (int i = 0; i < lanes; i++) begin
            if (arr_wr.en && arr_wr.mask[i]) begin
                mem[arr_wr_addr][i*lane_w +: lane_w] <= arr_wr.data[i*lane_w +: lane_w];
            end
        end
    end

    // Registered read, q keeps the last word when idle
    always_ff @(posedge clkdp) begin
        if (arr_rd) begin
            q <= mem[arr_rd_addr];
        end
    end

endmodule

// ==== design/ram_read_return.sv ====
`timescale 1ns/100ps

module ram_read_return import ram_pkg::*; (
    input  logic      clkdp,
    input  logic      rst,
    input  ram_data_t q,
    input  logic      rd_owner,
    input  logic      rd_issued,
    output ram_data_t rd_data,
    output ram_data_t capture_data
);

    logic rd_issued_q;

    // rd_issued_q lines up with the delayed owner flag from the mux
    always_ff @(posedge clkdp) begin
        if (rst) begin
            rd_issued_q <= 1'b0;
            rd_data <= '0;
        end else begin
            rd_issued_q <= rd_issued;
            if (rd_issued_q && !rd_owner) begin
                rd_data <= q;
            end
        end
    end

    // Test data goes back to rb_access, which loads it on capture
    assign capture_data = (rd_issued_q && rd_owner) ? q : '0;

endmodule

// ==== design/ram_dp_top.sv ====
`timescale 1ns/100ps

module ram_dp_top import ram_pkg::*; #(
    parameter int addr_w = 10
) (
    input  logic              clkdp,
    input  logic              rst,
    input  mem_wr_t           wr,
    input  logic [addr_w-1:0] wr_addr,
    input  logic              rd_en,
    input  logic [addr_w-1:0] rd_addr,
    output ram_data_t         rd_data,
    input  rb_req_t           rb_req,
    output ram_data_t         rb_rdata,
    output logic              rb_rvalid,
    output logic              rb_busy
);

    logic test_own;
    mem_wr_t test_wr;
    logic [addr_w-1:0] test_addr;
    logic test_rd;
    ram_data_t capture_data;
    mem_wr_t arr_wr;
    logic [addr_w-1:0] arr_wr_addr;
    logic arr_rd;
    logic [addr_w-1:0] arr_rd_addr;
    logic rd_owner;
    ram_data_t q;

    rb_access #(.addr_w(addr_w)) u_rb_access (
        .clkdp        (clkdp),
        .rst          (rst),
        .rb_req       (rb_req),
        .rb_rdata     (rb_rdata),
        .rb_rvalid    (rb_rvalid),
        .rb_busy      (rb_busy),
        .test_own     (test_own),
        .test_wr      (test_wr),
        .test_addr    (test_addr),
        .test_rd      (test_rd),
        .capture      (),
        .capture_data (capture_data)
    );

    ram_port_mux #(.addr_w(addr_w)) u_ram_port_mux (
        .clkdp        (clkdp),
        .rst          (rst),
        .test_own     (test_own),
        .func_wr      (wr),
        .func_wr_addr (wr_addr),
        .func_rd      (rd_en),
        .func_rd_addr (rd_addr),
        .test_wr      (test_wr),
        .test_addr    (test_addr),
        .test_rd      (test_rd),
        .arr_wr       (arr_wr),
        .arr_wr_addr  (arr_wr_addr),
        .arr_rd       (arr_rd),
        .arr_rd_addr  (arr_rd_addr),
        .rd_owner     (rd_owner)
    );

    ram_array #(.addr_w(addr_w)) u_ram_array (
        .clkdp       (clkdp),
        .arr_wr      (arr_wr),
        .arr_wr_addr (arr_wr_addr),
        .arr_rd      (arr_rd),
        .arr_rd_addr (arr_rd_addr),
        .q           (q)
    );

    ram_read_return u_ram_read_return (
        .clkdp        (clkdp),
        .rst          (rst),
        .q            (q),
        .rd_owner     (rd_owner),
        .rd_issued    (arr_rd),
        .rd_data      (rd_data),
        .capture_data (capture_data)
    );

endmodule

// ==== verif/ram_dp_checker.sv ====
`timescale 1ns/100ps

module ram_dp_checker import ram_pkg::*; (
    input logic    clkdp,
    input logic    rst,
    input rb_req_t rb_req,
    input logic    rb_rvalid,
    input logic    rb_busy,
    input logic    test_own,
    input mem_wr_t test_wr,
    input logic    test_rd,
    input mem_wr_t arr_wr
);

    logic cmd_wr;

    assign cmd_wr = rb_req.sel && rb_req.wr && (rb_req.reg_idx == rb_cmd_reg);

    // Register read data comes back as a one-cycle pulse
    rvalid_pulse: assert property (@(posedge clkdp) disable iff (rst)
        rb_rvalid |=> !rb_rvalid)
        else $error("rb_rvalid high for more than one cycle");

    // Two busy cycles at most, for a read command
    busy_len: assert property (@(posedge clkdp) disable iff (rst)
        rb_busy && $past(rb_busy) |=> !rb_busy)
        else $error("rb_busy high for more than two cycles");

    // A dropped command starts no array access
    cmd_ignored: assert property (@(posedge clkdp) disable iff (rst)
        cmd_wr && rb_busy |=> !(test_wr.en || test_rd))
        else $error("command accepted while rb_busy was high");

    no_func_wr: assert property (@(posedge clkdp) disable iff (rst)
        test_own && !test_wr.en |-> !arr_wr.en)
        else $error("functional write reached the array under test ownership");

endmodule

bind ram_dp_top ram_dp_checker u_ram_dp_checker (
    .clkdp     (clkdp),
    .rst       (rst),
    .rb_req    (rb_req),
    .rb_rvalid (rb_rvalid),
    .rb_busy   (rb_busy),
    .test_own  (test_own),
    .test_wr   (test_wr),
    .test_rd   (test_rd),
    .arr_wr    (arr_wr)
);

// ==== verif/ram_dp_tb.sv ====
`timescale 1ns/100ps

module ram_dp_tb import ram_pkg::*; ();

    localparam int addr_w = 10;
    localparam int n_rand = 12;
    // Reset, then cycles per test in run order, then a margin
    localparam int cycle_limit = 3 + (2 * n_rand + 3) + (2 * n_rand + 2) + 11 + 13 + 17 + 7 + 40;

    logic clkdp;
    logic rst;
    mem_wr_t wr;
    logic [addr_w-1:0] wr_addr;
    logic rd_en;
    logic [addr_w-1:0] rd_addr;
    ram_data_t rd_data;
    rb_req_t rb_req;
    ram_data_t rb_rdata;
    logic rb_rvalid;
    logic rb_busy;

    ram_data_t ref_mem [2**addr_w];
    logic ref_own;
    logic [addr_w-1:0] addr_list [n_rand];
    logic [31:0] lfsr = 32'h3916;
    ram_data_t exp_rb;
    ram_data_t exp_next;
    ram_data_t exp_rd;
    logic rd_due;
    int stim_errs = 0;
    int cmp_errs = 0;
    int cycles = 0;

    ram_dp_top #(.addr_w(addr_w)) u_ram_dp_top (.*);

    initial begin
        clkdp = 1'b0;
        forever #10 clkdp = ~clkdp;
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Merge the written lanes into the old word
    function automatic ram_data_t merge_lanes(input ram_data_t old, input ram_data_t data,
                                              input ram_mask_t mask);
        ram_data_t v;
        v = old;
        for (int i = 0; i < lanes; i++) begin
            if (mask[i]) begin
                v[i*lane_w +: lane_w] = data[i*lane_w +: lane_w];
            end
        end
        return v;
    endfunction

    function automatic ram_data_t ref_read_word(input logic [addr_w-1:0] a);
        return ref_mem[a];
    endfunction

    task automatic check_data(input string name, input ram_data_t exp, input ram_data_t act,
                              inout int errs);
        if (act !== exp) begin
            errs++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act,
                              inout int errs);
        if (act !== exp) begin
            errs++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic func_write(input logic [addr_w-1:0] a, input ram_data_t d,
                              input ram_mask_t m);
        wr = '{1'b1, m, d};
        wr_addr = a;
        // Dropped by the DUT while the test side owns the array
        if (!ref_own) begin
            ref_mem[a] = merge_lanes(ref_mem[a], d, m);
        end
        @(negedge clkdp);
        wr.en = 1'b0;
    endtask

    task automatic func_read(input logic [addr_w-1:0] a);
        rd_en = 1'b1;
        rd_addr = a;
        @(negedge clkdp);
        rd_en = 1'b0;
    endtask

    task automatic rb_write(input rb_reg_t idx, input ram_data_t d);
        rb_req = '{1'b1, 1'b1, idx, d};
        @(negedge clkdp);
        rb_req.sel = 1'b0;
    endtask

    // rvalid must show up exactly one cycle after the request edge
    task automatic rb_read(input rb_reg_t idx, input ram_data_t expected);
        rb_req = '{1'b1, 1'b0, idx, '0};
        @(negedge clkdp);
        rb_req.sel = 1'b0;
        exp_rb = expected;
        check_flag("rb_rvalid", 1'b0, rb_rvalid, stim_errs);
        @(negedge clkdp);
        check_flag("rb_rvalid", 1'b1, rb_rvalid, stim_errs);
    endtask

    // Poke sends a second command in the first busy cycle, which must be ignored
    task automatic rb_command(input rb_cmd_e cmd, input int busy_len, input logic poke);
        rb_write(rb_cmd_reg, ram_data_t'(cmd));
        for (int i = 0; i < busy_len; i++) begin
            check_flag("rb_busy", 1'b1, rb_busy, stim_errs);
            if (poke && i == 0) begin
                rb_req = '{1'b1, 1'b1, rb_cmd_reg, ram_data_t'(cmd_write)};
            end else begin
                rb_req.sel = 1'b0;
            end
            @(negedge clkdp);
        end
        rb_req.sel = 1'b0;
        check_flag("rb_busy", 1'b0, rb_busy, stim_errs);
    endtask

    task automatic test_write(input logic [addr_w-1:0] a, input ram_data_t d,
                              input ram_mask_t m);
        rb_write(rb_addr_reg, ram_data_t'(a));
        rb_write(rb_wdata_reg, d);
        rb_write(rb_mask_reg, ram_data_t'(m));
        rb_command(cmd_write, 1, 1'b0);
        ref_mem[a] = merge_lanes(ref_mem[a], d, m);
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        $display("Test %0d %s: %0d errors", num, name, stim_errs + cmp_errs - mark);
    endtask

    // Expected rd_data follows a functional read by one cycle and holds otherwise
    always @(posedge clkdp) begin
        if (rst) begin
            rd_due <= 1'b0;
            exp_next <= '0;
            exp_rd <= '0;
        end else begin
            rd_due <= rd_en && !ref_own;
            if (rd_en && !ref_own) begin
                exp_next <= ref_read_word(rd_addr);
            end
            if (rd_due) begin
                exp_rd <= exp_next;
            end
        end
    end

    // rd_data is compared every cycle to catch a wrong reset value or a lost hold
    always @(negedge clkdp) begin
        if (!rst) begin
            check_data("rd_data", exp_rd, rd_data, cmp_errs);
            if (rb_rvalid) begin
                check_data("rb_rdata", exp_rb, rb_rdata, cmp_errs);
            end
        end
    end

    always @(posedge clkdp) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int mark;
        logic [addr_w-1:0] a;
        rst = 1'b1;
        wr = '0;
        wr_addr = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        rb_req = '0;
        ref_own = 1'b0;
        exp_rb = '0;
        repeat (2) @(posedge clkdp);
        @(negedge clkdp);
        rst = 1'b0;

        mark = stim_errs + cmp_errs;
        for (int i = 0; i < n_rand; i++) begin
            addr_list[i] = addr_w'(take_bits(addr_w));
            func_write(addr_list[i], take_bits(data_w), 4'hf);
        end
        for (int i = 0; i < n_rand; i++) begin
            func_read(addr_list[i]);
        end
        repeat (3) @(negedge clkdp);
        report_test(1, "full-mask write and read", mark);

        mark = stim_errs + cmp_errs;
        for (int i = 0; i < n_rand; i++) begin
            func_write(addr_list[i], take_bits(data_w), ram_mask_t'(take_bits(lanes)));
            func_read(addr_list[i]);
        end
        repeat (2) @(negedge clkdp);
        report_test(2, "partial-mask write", mark);

        // New data lands in memory but rd_data keeps the old word until the next read
        mark = stim_errs + cmp_errs;
        func_read(addr_list[0]);
        repeat (2) @(negedge clkdp);
        func_write(addr_list[0], ~ref_read_word(addr_list[0]), 4'hf);
        repeat (4) @(negedge clkdp);
        func_read(addr_list[0]);
        repeat (2) @(negedge clkdp);
        report_test(3, "rd_data hold", mark);

        mark = stim_errs + cmp_errs;
        a = addr_w'(take_bits(addr_w));
        test_write(a, take_bits(data_w), 4'hf);
        rb_command(cmd_read, 2, 1'b0);
        rb_read(rb_rdata_reg, ref_read_word(a));
        func_read(a);
        repeat (2) @(negedge clkdp);
        report_test(4, "register-bus test access", mark);

        mark = stim_errs + cmp_errs;
        ref_own = 1'b1;
        rb_write(rb_ctrl_reg, 32'd1);
        rb_read(rb_ctrl_reg, 32'd1);
        func_write(addr_list[0], take_bits(data_w), 4'hf);
        func_read(addr_list[0]);
        repeat (2) @(negedge clkdp);
        test_write(addr_list[1], take_bits(data_w), 4'b0101);
        ref_own = 1'b0;
        rb_write(rb_ctrl_reg, 32'd0);
        func_read(addr_list[0]);
        func_read(addr_list[1]);
        repeat (2) @(negedge clkdp);
        report_test(5, "test ownership", mark);

        // The write command repeats the last test write so memory is unchanged
        mark = stim_errs + cmp_errs;
        rb_command(cmd_write, 1, 1'b1);
        rb_command(cmd_read, 2, 1'b1);
        rb_read(rb_cmd_reg, '0);
        report_test(6, "busy length", mark);

        $display("Tests 6, errors %0d", stim_errs + cmp_errs);
        if (stim_errs + cmp_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
design/ram_pkg.sv
design/rb_access.sv
design/ram_port_mux.sv
design/ram_array.sv
design/ram_read_return.sv
design/ram_dp_top.sv
verif/ram_dp_checker.sv
verif/ram_dp_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ram_dp_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
